// ==== filelist.f ====
hw/sw_frame_pkg.sv
hw/sw_ctrl_pkg.sv
hw/desc_bus_if.sv
hw/frame_fsm.sv
hw/word_counter.sv
hw/port_lane.sv
hw/desc_arbiter.sv
hw/desc_fifo.sv
hw/switch_ingress_ctrl.sv
verification/tb_switch_ingress.sv

// ==== hw/desc_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module desc_arbiter
    import sw_frame_pkg::*, sw_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              fifo_full,
    desc_bus_if.arb           bus,
    output logic              push,
    output logic [DESC_W-1:0] push_data,
    output logic [DROP_W-1:0] drop_count
);

    logic [PORT_W-1:0]    last_q;
    logic [PORT_W-1:0]    idx;
    logic [PORT_W-1:0]    gnt_idx;
    logic                 found;
    logic [NUM_PORTS-1:0] grant_c;
    logic [PORT_W:0]      drop_sum;
    logic [DROP_W:0]      drop_next;

    // Rotating search, starting one past the last granted slot
    always_comb
    begin
        found   = 1'b0;
        gnt_idx = last_q;
        idx     = last_q;
        for (int i = 1; i <= NUM_PORTS; i++)
        begin
            idx = PORT_W'(last_q + i);
            if (!found && bus.pend_valid[idx])
            begin
                found   = 1'b1;
                gnt_idx = idx;
            end
        end
    end

    assign push = found && !fifo_full;

    always_comb
    begin
        grant_c = '0;
        if (push)
            grant_c[gnt_idx] = 1'b1;
    end

    assign bus.grant = grant_c;

    always_comb
    begin
        push_data = '0;
        push_data[DESC_ERR_LSB]              = bus.pend_err[gnt_idx];
        push_data[DESC_LEN_LSB +: LEN_W]     = bus.pend_len[gnt_idx];
        push_data[DESC_PRIO_LSB +: PRIO_W]   = bus.pend_prio[gnt_idx];
        push_data[DESC_DEST_LSB +: DEST_W]   = bus.pend_dest[gnt_idx];
        push_data[DESC_PORT_LSB +: PORT_W]   = gnt_idx;   // slot is the source port
    end

    // Several lanes can drop in the same cycle
    always_comb
    begin
        drop_sum = '0;
        for (int i = 0; i < NUM_PORTS; i++)
            drop_sum = drop_sum + {{PORT_W{1'b0}}, bus.drop[i]};
    end

    assign drop_next = {1'b0, drop_count} + {{(DROP_W - PORT_W){1'b0}}, drop_sum};

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            last_q     <= PORT_W'(NUM_PORTS - 1);  // port 0 searched first
            drop_count <= '0;
        end
        else
        begin
            if (push)
                last_q <= gnt_idx;
            drop_count <= drop_next[DROP_W] ? '1 : drop_next[DROP_W-1:0];
        end
    end

    // Exactly one grant whenever a slot waits and the queue has room
    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(bus.grant) && ((|bus.grant) == (!fifo_full && (|bus.pend_valid))));

endmodule

`default_nettype wire

// ==== hw/desc_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface desc_bus_if
    import sw_frame_pkg::*, sw_ctrl_pkg::*;
();

    // One slot per port
    logic [NUM_PORTS-1:0]             pend_valid;
    logic [NUM_PORTS-1:0][DEST_W-1:0] pend_dest;
    logic [NUM_PORTS-1:0][PRIO_W-1:0] pend_prio;
    logic [NUM_PORTS-1:0][LEN_W-1:0]  pend_len;
    logic [NUM_PORTS-1:0]             pend_err;
    logic [NUM_PORTS-1:0]             drop;
    logic [NUM_PORTS-1:0]             grant;  // one cycle, clears pend_valid

    modport lane (
        output pend_valid, pend_dest, pend_prio, pend_len, pend_err, drop,
        input  grant
    );

    modport arb (
        input  pend_valid, pend_dest, pend_prio, pend_len, pend_err, drop,
        output grant
    );

endinterface

`default_nettype wire

// ==== hw/desc_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module desc_fifo
    import sw_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              push,
    input  logic              pop,
    input  logic [DESC_W-1:0] push_data,
    output logic [DESC_W-1:0] head,
    output logic              full,
    output logic              empty
);

    logic [DESC_W-1:0]  mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               wr_en;
    logic               rd_en;

    assign wr_en = push && !full;
    assign rd_en = pop && !empty;

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            if (wr_en && !rd_en)
                count <= count + 1'b1;
            else if (rd_en && !wr_en)
                count <= count - 1'b1;
        end
    end

    assign head  = mem[rd_ptr];  // fall-through
    assign empty = (count == '0);
    assign full  = (count == (FIFO_AW + 1)'(FIFO_DEPTH));

    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule

`default_nettype wire

// ==== hw/frame_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_fsm
    import sw_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sop,
    input  logic       vld,
    input  logic       eop,
    output logic [1:0] state,
    output logic       hdr_load,
    output logic       cnt_clear,
    output logic       cnt_inc,
    output logic       frame_done,
    output logic       frame_abort
);

    logic [1:0] state_next;
    logic       in_frame;

    assign in_frame = (state == ST_HEAD) || (state == ST_DATA);

    assign hdr_load    = (state == ST_HEAD) && vld && !sop;
    assign cnt_clear   = sop;                       // every new frame starts at zero
    assign cnt_inc     = in_frame && vld && !sop;
    assign frame_done  = in_frame && eop;
    assign frame_abort = in_frame && sop;           // frame cut off by a new sop

    always_comb
    begin
        state_next = state;
        if (sop)
        begin
            state_next = ST_HEAD;
        end
        else
        begin
            case (state)
                ST_HEAD:
                    if (eop)
                        state_next = ST_DONE;
                    else if (vld)
                        state_next = ST_DATA;
                ST_DATA:
                    if (eop)
                        state_next = ST_DONE;
                default:
                    state_next = ST_IDLE;           // IDLE, and DONE after one cycle
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= ST_IDLE;
        else
            state <= state_next;
    end

    // Input framing
    a_sop_eop_excl: assert property (@(posedge clk) disable iff (!rst_n) !(sop && eop));

endmodule

`default_nettype wire

// ==== hw/port_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module port_lane
    import sw_frame_pkg::*, sw_ctrl_pkg::*;
#(
    parameter int PORT_ID = 0
)
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            sop,
    input  logic            vld,
    input  logic            eop,
    input  frame_word_u     data,
    desc_bus_if.lane        bus
);

    logic [1:0]        lane_state;
    logic              hdr_load;
    logic              cnt_clear;
    logic              cnt_inc;
    logic              frame_done;
    logic              frame_abort;
    logic [LEN_W-1:0]  count;
    logic              len_ok;
    frame_word_u       hdr_q;
    logic              hdr_seen;
    logic              frame_end;
    logic              granted;
    logic              take_desc;
    logic              pend_valid_q;
    logic [DEST_W-1:0] pend_dest_q;
    logic [PRIO_W-1:0] pend_prio_q;
    logic [LEN_W-1:0]  pend_len_q;
    logic              pend_err_q;
    logic              drop_q;

    frame_fsm u_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .sop         (sop),
        .vld         (vld),
        .eop         (eop),
        .state       (lane_state),
        .hdr_load    (hdr_load),
        .cnt_clear   (cnt_clear),
        .cnt_inc     (cnt_inc),
        .frame_done  (frame_done),
        .frame_abort (frame_abort)
    );

    word_counter u_cnt (
        .clk     (clk),
        .rst_n   (rst_n),
        .clear   (cnt_clear),
        .inc     (cnt_inc),
        .hdr_len (hdr_q.hdr.len),
        .count   (count),
        .len_ok  (len_ok)
    );

    // Header fields only mean something once the header word was taken
    assign hdr_seen  = (lane_state == ST_DATA);
    assign frame_end = frame_done || frame_abort;
    assign granted   = bus.grant[PORT_ID];
    assign take_desc = frame_end && (!pend_valid_q || granted);

    always_ff @(posedge clk)
    begin
        if (hdr_load)
            hdr_q.raw <= data.raw;
        if (take_desc)
        begin
            pend_dest_q <= hdr_seen ? hdr_q.hdr.dest : '0;
            pend_prio_q <= hdr_seen ? hdr_q.hdr.prio : '0;
            pend_len_q  <= count;
            pend_err_q  <= frame_abort || !hdr_seen || !len_ok;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pend_valid_q <= 1'b0;
            drop_q       <= 1'b0;
        end
        else
        begin
            drop_q <= frame_end && pend_valid_q && !granted;  // slot still occupied
            if (take_desc)
                pend_valid_q <= 1'b1;
            else if (granted)
                pend_valid_q <= 1'b0;
        end
    end

    assign bus.pend_valid[PORT_ID] = pend_valid_q;
    assign bus.pend_dest[PORT_ID]  = pend_dest_q;
    assign bus.pend_prio[PORT_ID]  = pend_prio_q;
    assign bus.pend_len[PORT_ID]   = pend_len_q;
    assign bus.pend_err[PORT_ID]   = pend_err_q;
    assign bus.drop[PORT_ID]       = drop_q;

    // Arbiter must only grant a slot that holds a descriptor
    a_grant_pending: assert property (@(posedge clk) disable iff (!rst_n)
        granted |-> pend_valid_q);

endmodule

`default_nettype wire

// ==== hw/sw_ctrl_pkg.sv ====
`default_nettype none

package sw_ctrl_pkg;

    localparam int NUM_PORTS = 16;
    localparam int PORT_W    = 4;

    // Descriptor layout, LSB first: err, len, prio, dest, source port
    localparam int DESC_ERR_LSB  = 0;
    localparam int DESC_LEN_LSB  = 1;
    localparam int DESC_PRIO_LSB = 10;
    localparam int DESC_DEST_LSB = 13;
    localparam int DESC_PORT_LSB = 17;
    localparam int DESC_W        = 21;

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = 4;

    // Lane FSM
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_HEAD = 2'd1;  // sop seen, waiting for header word
    localparam logic [1:0] ST_DATA = 2'd2;
    localparam logic [1:0] ST_DONE = 2'd3;

    localparam int DROP_W = 16;

endpackage

`default_nettype wire

// ==== hw/sw_frame_pkg.sv ====
`default_nettype none

package sw_frame_pkg;

    localparam int WORD_W  = 16;
    localparam int LEN_W   = 9;
    localparam int PRIO_W  = 3;
    localparam int DEST_W  = 4;

    // Length counts the header word too
    localparam int MAX_LEN = (1 << LEN_W) - 1;

    // First valid word of a frame is read as a header, later words as raw payload
    typedef union packed {
        logic [WORD_W-1:0] raw;
        struct packed {
            logic [LEN_W-1:0]  len;   // [15:7]
            logic [PRIO_W-1:0] prio;  // [6:4]
            logic [DEST_W-1:0] dest;  // [3:0]
        } hdr;
    } frame_word_u;

endpackage

`default_nettype wire

// ==== hw/switch_ingress_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module switch_ingress_ctrl
    import sw_frame_pkg::*, sw_ctrl_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [NUM_PORTS-1:0]              wr_sop,
    input  logic [NUM_PORTS-1:0]              wr_vld,
    input  logic [NUM_PORTS-1:0]              wr_eop,
    input  logic [NUM_PORTS-1:0][WORD_W-1:0]  wr_data,
    input  logic                              desc_pop,
    output logic                              desc_empty,
    output logic [PORT_W-1:0]                 desc_port,
    output logic [DEST_W-1:0]                 desc_dest,
    output logic [PRIO_W-1:0]                 desc_prio,
    output logic [LEN_W-1:0]                  desc_len,
    output logic                              desc_err,
    output logic [DROP_W-1:0]                 drop_count
);

    logic              push;
    logic [DESC_W-1:0] push_data;
    logic [DESC_W-1:0] fifo_head;
    logic              fifo_full;

    desc_bus_if bus ();

    for (genvar g = 0; g < NUM_PORTS; g++)
    begin : g_lane
        port_lane #(.PORT_ID(g)) u_lane (
            .clk   (clk),
            .rst_n (rst_n),
            .sop   (wr_sop[g]),
            .vld   (wr_vld[g]),
            .eop   (wr_eop[g]),
            .data  (wr_data[g]),
            .bus   (bus.lane)
        );
    end

    desc_arbiter u_arb (
        .clk        (clk),
        .rst_n      (rst_n),
        .fifo_full  (fifo_full),
        .bus        (bus.arb),
        .push       (push),
        .push_data  (push_data),
        .drop_count (drop_count)
    );

    desc_fifo u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .pop       (desc_pop),
        .push_data (push_data),
        .head      (fifo_head),
        .full      (fifo_full),
        .empty     (desc_empty)
    );

    // Head of queue split into fields
    assign desc_port = fifo_head[DESC_PORT_LSB +: PORT_W];
    assign desc_dest = fifo_head[DESC_DEST_LSB +: DEST_W];
    assign desc_prio = fifo_head[DESC_PRIO_LSB +: PRIO_W];
    assign desc_len  = fifo_head[DESC_LEN_LSB +: LEN_W];
    assign desc_err  = fifo_head[DESC_ERR_LSB];

endmodule

`default_nettype wire

// ==== hw/word_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module word_counter
    import sw_frame_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             clear,
    input  logic             inc,
    input  logic [LEN_W-1:0] hdr_len,
    output logic [LEN_W-1:0] count,
    output logic             len_ok
);

    logic ovf;  // sticky, frame ran past MAX_LEN

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            count <= '0;
            ovf   <= 1'b0;
        end
        else if (clear)
        begin
            count <= '0;
            ovf   <= 1'b0;
        end
        else if (inc)
        begin
            if (count == LEN_W'(MAX_LEN))
                ovf <= 1'b1;                    // hold count, remember the overrun
            else
                count <= count + 1'b1;
        end
    end

    // Zero length is never legal
    assign len_ok = !ovf && (count == hdr_len) && (hdr_len != '0);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ingress controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_switch_ingress -f filelist.f

# Show the simulation output and pass only when the pass line is present
./obj_dir/Vtb_switch_ingress | tee /dev/stderr | grep -q -F "*** TEST PASSED ***"
echo "run_sim: simulation passed"

// ==== verification/tb_switch_ingress.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_switch_ingress
    import sw_frame_pkg::*, sw_ctrl_pkg::*;
();

    logic                             clk;
    logic                             rst_n;
    logic [NUM_PORTS-1:0]             wr_sop;
    logic [NUM_PORTS-1:0]             wr_vld;
    logic [NUM_PORTS-1:0]             wr_eop;
    logic [NUM_PORTS-1:0][WORD_W-1:0] wr_data;
    logic                             desc_pop;
    logic                             desc_empty;
    logic [PORT_W-1:0]                desc_port;
    logic [DEST_W-1:0]                desc_dest;
    logic [PRIO_W-1:0]                desc_prio;
    logic [LEN_W-1:0]                 desc_len;
    logic                             desc_err;
    logic [DROP_W-1:0]                drop_count;

    int                seed;
    logic              auto_pop;        // Consumer drains the queue when set
    logic [DESC_W-1:0] exp_q [NUM_PORTS][$];

    switch_ingress_ctrl dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_sop     (wr_sop),
        .wr_vld     (wr_vld),
        .wr_eop     (wr_eop),
        .wr_data    (wr_data),
        .desc_pop   (desc_pop),
        .desc_empty (desc_empty),
        .desc_port  (desc_port),
        .desc_dest  (desc_dest),
        .desc_prio  (desc_prio),
        .desc_len   (desc_len),
        .desc_err   (desc_err),
        .drop_count (drop_count)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            fail_run($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    // Expected descriptor from header and words actually sent
    function automatic logic [DESC_W-1:0] expect_desc(input int port, input frame_word_u hw,
                                                      input int sent, input bit cut);
        logic [DESC_W-1:0] d;
        int                counted;
        bit                err;
        counted = (sent > MAX_LEN) ? MAX_LEN : sent;
        err = cut || (sent != int'(hw.hdr.len)) || (hw.hdr.len == '0);
        d = '0;
        d[DESC_PORT_LSB +: PORT_W] = PORT_W'(port);
        if (sent > 0)
        begin
            d[DESC_DEST_LSB +: DEST_W] = hw.hdr.dest;
            d[DESC_PRIO_LSB +: PRIO_W] = hw.hdr.prio;
        end
        d[DESC_LEN_LSB +: LEN_W] = LEN_W'(counted);
        d[DESC_ERR_LSB] = err;
        return d;
    endfunction

    function automatic frame_word_u make_hdr(input int len, input int prio, input int dest);
        frame_word_u hw;
        hw.hdr.len  = LEN_W'(len);
        hw.hdr.prio = PRIO_W'(prio);
        hw.hdr.dest = DEST_W'(dest);
        return hw;
    endfunction

    function automatic logic [WORD_W-1:0] payload_word(input int port, input int idx);
        return WORD_W'((port << 12) ^ (idx * 37));
    endfunction

    function automatic int outstanding();
        int n;
        n = 0;
        for (int p = 0; p < NUM_PORTS; p++)
            n += exp_q[p].size();
        return n;
    endfunction

    task automatic queue_expect(input int port, input frame_word_u hw, input int sent,
                                input bit cut);
        exp_q[port].push_back(expect_desc(port, hw, sent, cut));
    endtask

    // sop, then nwords valid words starting with the header, then eop if asked
    task automatic send_frame(input int port, input frame_word_u hw, input int nwords,
                              input bit with_eop);
        @(posedge clk);
        #1 wr_sop[port] = 1'b1;
        for (int i = 0; i < nwords; i++)
        begin
            @(posedge clk);
            #1;
            wr_sop[port]  = 1'b0;
            wr_vld[port]  = 1'b1;
            wr_data[port] = (i == 0) ? hw.raw : payload_word(port, i);
        end
        @(posedge clk);
        #1;
        wr_sop[port] = 1'b0;
        wr_vld[port] = 1'b0;
        wr_eop[port] = with_eop;
        if (with_eop)
        begin
            @(posedge clk);
            #1 wr_eop[port] = 1'b0;
        end
    endtask

    // One random frame on every port, each after its own idle gap
    task automatic run_round();
        int          start_c [NUM_PORTS];
        int          nw [NUM_PORTS];
        frame_word_u head_w [NUM_PORTS];
        int          last;
        int          rel;
        last = 0;
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            start_c[p] = $unsigned($random(seed)) % 8;
            nw[p]      = 1 + $unsigned($random(seed)) % 12;
            head_w[p]  = make_hdr(nw[p], $unsigned($random(seed)) % 8,
                                  $unsigned($random(seed)) % 16);
            queue_expect(p, head_w[p], nw[p], 1'b0);
            if (start_c[p] + nw[p] + 2 > last)
                last = start_c[p] + nw[p] + 2;
        end
        for (int t = 0; t <= last; t++)
        begin
            @(posedge clk);
            #1;
            for (int p = 0; p < NUM_PORTS; p++)
            begin
                rel = t - start_c[p];
                wr_sop[p]  = (rel == 0);
                wr_vld[p]  = (rel >= 1) && (rel <= nw[p]);
                wr_eop[p]  = (rel == nw[p] + 1);
                wr_data[p] = (rel == 1) ? head_w[p].raw : payload_word(p, rel);
            end
        end
    endtask

    task automatic wait_drain(input int limit);
        int cycles;
        cycles = 0;
        while (outstanding() != 0 || !desc_empty)
        begin
            @(posedge clk);
            #1 cycles++;
            if (cycles > limit)
                fail_run("timed out waiting for the expected descriptors to arrive");
        end
    endtask

    // Consumer and compare, the source port selects the expected queue
    initial
    begin
        logic [DESC_W-1:0] exp_d;
        int                p;
        desc_pop = 1'b0;
        forever
        begin
            @(posedge clk);
            #1;
            if (rst_n && auto_pop && !desc_empty)
            begin
                p = int'(desc_port);
                if (exp_q[p].size() == 0)
                    fail_run($sformatf("unexpected descriptor from port %0d", p));
                exp_d = exp_q[p].pop_front();
                check_val("desc_dest", 32'(desc_dest), 32'(exp_d[DESC_DEST_LSB +: DEST_W]));
                check_val("desc_prio", 32'(desc_prio), 32'(exp_d[DESC_PRIO_LSB +: PRIO_W]));
                check_val("desc_len", 32'(desc_len), 32'(exp_d[DESC_LEN_LSB +: LEN_W]));
                check_val("desc_err", 32'(desc_err), 32'(exp_d[DESC_ERR_LSB]));
                desc_pop = 1'b1;
            end
            else
                desc_pop = 1'b0;
        end
    end

    initial
    begin
        frame_word_u h;
        int          cycles;
        seed     = 95;
        auto_pop = 1'b1;
        rst_n    = 1'b0;
        wr_sop   = '0;
        wr_vld   = '0;
        wr_eop   = '0;
        wr_data  = '0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        check_val("desc_empty", 32'(desc_empty), 32'd1);
        check_val("drop_count", 32'(drop_count), 32'd0);

        h = make_hdr(33, 3, 9);               // Reference frame on port 5
        queue_expect(5, h, 33, 1'b0);
        send_frame(5, h, 33, 1'b1);
        wait_drain(200);

        h = make_hdr(10, 1, 2);               // short
        queue_expect(2, h, 7, 1'b0);
        send_frame(2, h, 7, 1'b1);
        h = make_hdr(10, 6, 11);              // long
        queue_expect(3, h, 14, 1'b0);
        send_frame(3, h, 14, 1'b1);
        h = make_hdr(0, 2, 7);                // zero length
        queue_expect(4, h, 4, 1'b0);
        send_frame(4, h, 4, 1'b1);
        wait_drain(200);

        repeat (6)
        begin
            run_round();
            wait_drain(400);
        end
        check_val("drop_count", 32'(drop_count), 32'd0);

        // Frame cut off after 8 words by a new sop
        h = make_hdr(20, 5, 1);
        queue_expect(9, h, 8, 1'b1);
        send_frame(9, h, 8, 1'b0);
        h = make_hdr(6, 4, 14);
        queue_expect(9, h, 6, 1'b0);
        send_frame(9, h, 6, 1'b1);
        wait_drain(200);

        // Queue fills, one held in the lane, the last frame is dropped
        auto_pop = 1'b0;
        for (int i = 0; i < 18; i++)
        begin
            h = make_hdr(i % 5 + 2, i % 8, 15 - i);
            if (i < 17)
                queue_expect(0, h, i % 5 + 2, 1'b0);
            send_frame(0, h, i % 5 + 2, 1'b1);
        end
        cycles = 0;
        while (drop_count == '0)
        begin
            @(posedge clk);
            #1 cycles++;
            if (cycles > 50)
                fail_run("timed out waiting for the dropped frame to be counted");
        end
        check_val("drop_count", 32'(drop_count), 32'd1);
        check_val("desc_empty", 32'(desc_empty), 32'd0);
        auto_pop = 1'b1;
        wait_drain(400);
        repeat (5) @(posedge clk);
        #1;
        check_val("drop_count", 32'(drop_count), 32'd1);
        check_val("desc_empty", 32'(desc_empty), 32'd1);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
